/* list.f */
+incdir+hdl
hdl/axiPkg.sv
hdl/routePkg.sv
hdl/axiIfs.sv
hdl/arRouter.sv
hdl/defaultSlave.sv
hdl/readDataRouter.sv
hdl/axiReadXbar.sv
tb/readChecker.sv
tb/tbAxiRead.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it, and pass only if the pass message shows up
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tbAxiRead -f list.f \
	&& ./obj_dir/VtbAxiRead | tee /dev/stderr | grep "ALL CHECKS PASSED" > /dev/null \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

/* tb/tbAxiRead.sv */
`timescale 1ns/10ps
`default_nettype none
`include "axi_macros.svh"

module tbAxiRead;

	localparam int numEntries = 16;

	logic ACLK;
	logic rst;

	// Master side, indexed by master number
	logic [1:0] arValid;
	axiPkg::masterIdT [1:0] arId;
	axiPkg::addrT [1:0] arAddr;
	axiPkg::lenT [1:0] arLen;
	logic [1:0] rReady = '0;
	wire [1:0] arReady;
	wire [1:0] rValid;
	wire [1:0] rLast;
	wire [1:0][3:0] rId;
	wire [1:0][31:0] rData;
	wire [1:0][1:0] rResp;

	// Slave side, indexed by slave number
	wire [1:0] sArValid;
	wire [1:0][7:0] sArId;
	wire [1:0][31:0] sArAddr;
	wire [1:0][3:0] sArLen;
	wire [1:0][2:0] sArSize;
	wire [1:0][1:0] sArBurst;
	wire [1:0] sRReady;
	logic [1:0] sArReady = '0;
	logic [1:0] sRValid = '0;
	logic [1:0] sRLast = '0;
	logic [1:0][7:0] sRId = '0;
	logic [1:0][31:0] sRData = '0;
	logic [1:0][1:0] sRResp = '0;

	// Slave model state
	logic [1:0] busy;
	axiPkg::addrT [1:0] bAddr;
	axiPkg::slaveIdT [1:0] bId;
	axiPkg::lenT [1:0] bLen;
	axiPkg::lenT [1:0] bBeat;
	int hits[2];

	// Stimulus table, a set pair flag issues the entry together with the next one
	int eMaster[numEntries];
	axiPkg::masterIdT eId[numEntries];
	axiPkg::addrT eAddr[numEntries];
	axiPkg::lenT eLen[numEntries];
	routePkg::targetT eTarget[numEntries];
	logic eStall[numEntries];
	logic ePair[numEntries];

	logic stallOn;
	int bursts;
	int cycles;
	int cycleLimit;
	int tbErrors;
	int chkErrors;
	int chkPending;

	axiReadXbar DUT (
		.ACLK(ACLK),
		.rst(rst),
		.ARID_M0(arId[0]),
		.ARADDR_M0(arAddr[0]),
		.ARLEN_M0(arLen[0]),
		.ARSIZE_M0(3'd2),
		.ARBURST_M0(2'b01),
		.ARVALID_M0(arValid[0]),
		.ARREADY_M0(arReady[0]),
		.RID_M0(rId[0]),
		.RDATA_M0(rData[0]),
		.RRESP_M0(rResp[0]),
		.RLAST_M0(rLast[0]),
		.RVALID_M0(rValid[0]),
		.RREADY_M0(rReady[0]),
		.ARID_M1(arId[1]),
		.ARADDR_M1(arAddr[1]),
		.ARLEN_M1(arLen[1]),
		.ARSIZE_M1(3'd2),
		.ARBURST_M1(2'b01),
		.ARVALID_M1(arValid[1]),
		.ARREADY_M1(arReady[1]),
		.RID_M1(rId[1]),
		.RDATA_M1(rData[1]),
		.RRESP_M1(rResp[1]),
		.RLAST_M1(rLast[1]),
		.RVALID_M1(rValid[1]),
		.RREADY_M1(rReady[1]),
		.ARID_S0(sArId[0]),
		.ARADDR_S0(sArAddr[0]),
		.ARLEN_S0(sArLen[0]),
		.ARSIZE_S0(sArSize[0]),
		.ARBURST_S0(sArBurst[0]),
		.ARVALID_S0(sArValid[0]),
		.ARREADY_S0(sArReady[0]),
		.RID_S0(sRId[0]),
		.RDATA_S0(sRData[0]),
		.RRESP_S0(sRResp[0]),
		.RLAST_S0(sRLast[0]),
		.RVALID_S0(sRValid[0]),
		.RREADY_S0(sRReady[0]),
		.ARID_S1(sArId[1]),
		.ARADDR_S1(sArAddr[1]),
		.ARLEN_S1(sArLen[1]),
		.ARSIZE_S1(sArSize[1]),
		.ARBURST_S1(sArBurst[1]),
		.ARVALID_S1(sArValid[1]),
		.ARREADY_S1(sArReady[1]),
		.RID_S1(sRId[1]),
		.RDATA_S1(sRData[1]),
		.RRESP_S1(sRResp[1]),
		.RLAST_S1(sRLast[1]),
		.RVALID_S1(sRValid[1]),
		.RREADY_S1(sRReady[1])
	);

	readChecker chk (
		.ACLK(ACLK),
		.rst(rst),
		.arValid(arValid),
		.arReady(arReady),
		.arId(arId),
		.arAddr(arAddr),
		.arLen(arLen),
		.sArValid(sArValid),
		.sArReady(sArReady),
		.sArSize(sArSize),
		.sArBurst(sArBurst),
		.rValid(rValid),
		.rReady(rReady),
		.rLast(rLast),
		.rId(rId),
		.rData(rData),
		.rResp(rResp),
		.errorCount(chkErrors),
		.pendingBeats(chkPending)
	);

	initial begin
		ACLK = 1'b0;
		forever #4 ACLK = ~ACLK;
	end

	// Slave models, one burst at a time
	always @(posedge ACLK) begin
		if (rst) begin
			busy <= '0;
			bBeat <= '0;
			bLen <= '0;
			hits[0] <= 0;
			hits[1] <= 0;
		end else begin
			for (int s = 0; s < 2; s++) begin
				if (!busy[s] && sArValid[s] && sArReady[s]) begin
					busy[s] <= 1'b1;
					bAddr[s] <= sArAddr[s];
					bId[s] <= sArId[s];
					bLen[s] <= sArLen[s];
					bBeat[s] <= '0;
					hits[s] <= hits[s] + 1;
				end else if (busy[s] && sRValid[s] && sRReady[s]) begin
					if (bBeat[s] == bLen[s])
						busy[s] <= 1'b0;
					else
						bBeat[s] <= bBeat[s] + 4'd1;
				end
			end
		end
	end

	always @(negedge ACLK) begin
		for (int s = 0; s < 2; s++) begin
			sArReady[s] = !busy[s];
			sRValid[s] = busy[s];
			sRId[s] = bId[s];
			sRLast[s] = busy[s] && (bBeat[s] == bLen[s]);
			sRResp[s] = `RESP_OKAY;
			sRData[s] = bAddr[s] + 32'(bBeat[s]) * 4;
			// S1 returns inverted data
			if (s == 1)
				sRData[s] = ~sRData[s];
		end
		for (int m = 0; m < 2; m++)
			rReady[m] = stallOn ? ($urandom % 4 != 0) : 1'b1;
	end

	// Completed bursts as seen on the master ports
	always @(posedge ACLK) begin
		if (rst)
			bursts <= 0;
		else if (|(rValid & rReady & rLast))
			bursts <= bursts + 1;
	end

	task automatic setEntry(input int idx, input int m, input axiPkg::masterIdT id,
			input axiPkg::addrT addr, input axiPkg::lenT len, input routePkg::targetT tgt,
			input logic stall, input logic pair);
		eMaster[idx] = m;
		eId[idx] = id;
		eAddr[idx] = addr;
		eLen[idx] = len;
		eTarget[idx] = tgt;
		eStall[idx] = stall;
		ePair[idx] = pair;
	endtask

	task automatic issueAr(input int idx);
		int m;
		m = eMaster[idx];
		@(negedge ACLK);
		arId[m] = eId[idx];
		arAddr[m] = eAddr[idx];
		arLen[m] = eLen[idx];
		arValid[m] = 1'b1;
		@(posedge ACLK);
		while (!arReady[m])
			@(posedge ACLK);
		@(negedge ACLK);
		arValid[m] = 1'b0;
	endtask

	task automatic compareCount(input string name, input int got, input int want);
		if (got != want) begin
			$display("%s received %0d read requests instead of %0d", name, got, want);
			tbErrors++;
		end
	endtask

	initial begin
		int i;
		int want;
		int expHits[3];
		void'($urandom(32'h3787));
		rst = 1'b1;
		arValid = '0;
		arId = '0;
		arAddr = '0;
		arLen = '0;
		stallOn = 1'b0;
		tbErrors = 0;
		want = 0;

		setEntry(0, 0, 4'h3, 32'h0000_0100, 4'd3, routePkg::tgtS0, 1'b0, 1'b1);
		setEntry(1, 1, 4'h5, 32'h0001_0040, 4'd2, routePkg::tgtS1, 1'b0, 1'b0);
		setEntry(2, 0, 4'h1, 32'h0000_0000, 4'd0, routePkg::tgtS0, 1'b0, 1'b0);
		setEntry(3, 1, 4'h2, 32'h0001_0200, 4'd7, routePkg::tgtS1, 1'b0, 1'b0);
		setEntry(4, 0, 4'h9, 32'h0002_0000, 4'd1, routePkg::tgtDefault, 1'b0, 1'b0);
		setEntry(5, 1, 4'hA, 32'h8000_0010, 4'd3, routePkg::tgtDefault, 1'b0, 1'b0);
		setEntry(6, 0, 4'h4, 32'h0000_FFF0, 4'd3, routePkg::tgtS0, 1'b0, 1'b0);
		setEntry(7, 1, 4'h6, 32'h0001_FFFC, 4'd0, routePkg::tgtS1, 1'b0, 1'b0);
		setEntry(8, 0, 4'h7, 32'h0000_1000, 4'd5, routePkg::tgtS0, 1'b1, 1'b1);
		setEntry(9, 1, 4'h8, 32'h0001_1000, 4'd4, routePkg::tgtS1, 1'b1, 1'b0);
		setEntry(10, 0, 4'hF, 32'h0000_2000, 4'd15, routePkg::tgtS0, 1'b1, 1'b0);
		setEntry(11, 0, 4'hB, 32'hFFFF_FFF0, 4'd2, routePkg::tgtDefault, 1'b1, 1'b0);
		// M0 was granted last, so M1 must win this tie
		setEntry(12, 1, 4'hC, 32'h0001_3000, 4'd3, routePkg::tgtS1, 1'b1, 1'b1);
		setEntry(13, 0, 4'hD, 32'h0003_0000, 4'd1, routePkg::tgtDefault, 1'b1, 1'b0);
		setEntry(14, 0, 4'h2, 32'h0000_8000, 4'd7, routePkg::tgtS0, 1'b1, 1'b0);
		setEntry(15, 1, 4'h1, 32'h0001_8000, 4'd15, routePkg::tgtS1, 1'b0, 1'b0);

		// Generous budget per burst on top of the reset cycles
		cycleLimit = 16;
		for (i = 0; i < numEntries; i++) begin
			cycleLimit += (int'(eLen[i]) + 1) * 4 + 20;
			expHits[int'(eTarget[i])]++;
		end

		repeat (16) @(posedge ACLK);
		@(negedge ACLK);
		if (arReady != 2'b00 || rValid != 2'b00 || sArValid != 2'b00 || sRReady != 2'b00) begin
			$display("Handshake outputs were not idle at the end of reset");
			tbErrors++;
		end
		rst = 1'b0;

		i = 0;
		while (i < numEntries) begin
			stallOn = eStall[i];
			if (ePair[i]) begin
				fork
					issueAr(i);
					issueAr(i + 1);
				join
				want += 2;
				i += 2;
			end else begin
				issueAr(i);
				want += 1;
				i += 1;
			end
			while (bursts < want)
				@(posedge ACLK);
		end
		// A few idle cycles to catch stray beats
		repeat (4) @(posedge ACLK);

		if (chkPending != 0) begin
			$display("%0d expected read beats never arrived", chkPending);
			tbErrors++;
		end
		compareCount("Slave S0", hits[0], expHits[0]);
		compareCount("Slave S1", hits[1], expHits[1]);
		compareCount("Default slave", bursts - hits[0] - hits[1], expHits[2]);

		$display("Run finished: %0d checker errors, %0d testbench errors", chkErrors, tbErrors);
		if (chkErrors == 0 && tbErrors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

	// Watchdog
	initial begin
		cycles = 0;
		@(posedge ACLK);
		while (cycles < cycleLimit) begin
			@(posedge ACLK);
			cycles++;
		end
		$display("Timeout, the tests did not finish within %0d cycles", cycleLimit);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* tb/readChecker.sv */
`timescale 1ns/10ps
`default_nettype none
`include "axi_macros.svh"

module readChecker (
	input wire logic ACLK,
	input wire logic rst,
	input wire logic [1:0] arValid,
	input wire logic [1:0] arReady,
	input wire axiPkg::masterIdT [1:0] arId,
	input wire axiPkg::addrT [1:0] arAddr,
	input wire axiPkg::lenT [1:0] arLen,
	input wire logic [1:0] sArValid,
	input wire logic [1:0] sArReady,
	input wire axiPkg::sizeT [1:0] sArSize,
	input wire axiPkg::burstT [1:0] sArBurst,
	input wire logic [1:0] rValid,
	input wire logic [1:0] rReady,
	input wire logic [1:0] rLast,
	input wire axiPkg::masterIdT [1:0] rId,
	input wire axiPkg::dataT [1:0] rData,
	input wire axiPkg::respT [1:0] rResp,
	output int errorCount,
	output int pendingBeats
);

	// One expected read beat
	typedef struct packed {
		logic master;
		logic last;
		axiPkg::masterIdT id;
		axiPkg::respT resp;
		axiPkg::dataT data;
	} beatT;

	// Bursts never overlap, so one queue in AR order serves both masters
	beatT expQ[$];
	int lastGrant;

	task automatic predictBurst(input int m);
		beatT b;
		axiPkg::addrT a;
		for (int k = 0; k <= int'(arLen[m]); k++) begin
			a = arAddr[m] + 32'(4 * k);
			b.master = m[0];
			b.last = (k == int'(arLen[m]));
			b.id = arId[m];
			// S0 window starts at address zero
			if (arAddr[m] < `S0_BASE + `SLAVE_SPAN) begin
				b.data = a;
				b.resp = `RESP_OKAY;
			end else if (arAddr[m] >= `S1_BASE && arAddr[m] < `S1_BASE + `SLAVE_SPAN) begin
				b.data = ~a;
				b.resp = `RESP_OKAY;
			end else begin
				b.data = '0;
				b.resp = `RESP_DECERR;
			end
			expQ.push_back(b);
		end
	endtask

	task automatic compareField(input string name, input int m, input logic [31:0] got,
			input logic [31:0] want);
		if (got !== want) begin
			$display("Error: %s%0d = 0x%h, expected 0x%h", name, m, got, want);
			errorCount++;
		end
	endtask

	always @(posedge ACLK) begin
		beatT b;
		if (rst) begin
			expQ.delete();
			// M0 wins the first tie
			lastGrant = 1;
			errorCount = 0;
		end else begin
			if ((arValid & arReady) == 2'b11) begin
				$display("Both masters got an AR handshake in the same cycle");
				errorCount++;
			end
			for (int m = 0; m < 2; m++) begin
				if (arValid[m] && arReady[m]) begin
					if (arValid == 2'b11 && m == lastGrant) begin
						$display("Arbiter granted M%0d twice in a row with both requesting", m);
						errorCount++;
					end
					lastGrant = m;
					predictBurst(m);
				end
			end
			// Masters only issue 4-byte INCR bursts
			for (int s = 0; s < 2; s++) begin
				if (sArValid[s] && sArReady[s]) begin
					compareField("ARSIZE_S", s, 32'(sArSize[s]), 32'(3'd2));
					compareField("ARBURST_S", s, 32'(sArBurst[s]), 32'(2'b01));
				end
			end
			for (int m = 0; m < 2; m++) begin
				if (rValid[m]) begin
					if (expQ.size() == 0 || expQ[0].master != m[0]) begin
						$display("RVALID on M%0d while no beat is due for that master", m);
						errorCount++;
					end else if (rReady[m]) begin
						b = expQ.pop_front();
						compareField("RDATA_M", m, rData[m], b.data);
						compareField("RRESP_M", m, 32'(rResp[m]), 32'(b.resp));
						compareField("RID_M", m, 32'(rId[m]), 32'(b.id));
						compareField("RLAST_M", m, 32'(rLast[m]), 32'(b.last));
					end
				end
			end
		end
		pendingBeats = expQ.size();
	end

endmodule

`default_nettype wire

/* hdl/axiReadXbar.sv */
`timescale 1ns/10ps
`default_nettype none

module axiReadXbar (
	input wire logic ACLK,
	input wire logic rst,

	// Master 0
	input wire axiPkg::masterIdT ARID_M0,
	input wire axiPkg::addrT ARADDR_M0,
	input wire axiPkg::lenT ARLEN_M0,
	input wire axiPkg::sizeT ARSIZE_M0,
	input wire axiPkg::burstT ARBURST_M0,
	input wire logic ARVALID_M0,
	output logic ARREADY_M0,
	output axiPkg::masterIdT RID_M0,
	output axiPkg::dataT RDATA_M0,
	output axiPkg::respT RRESP_M0,
	output logic RLAST_M0,
	output logic RVALID_M0,
	input wire logic RREADY_M0,

	// Master 1
	input wire axiPkg::masterIdT ARID_M1,
	input wire axiPkg::addrT ARADDR_M1,
	input wire axiPkg::lenT ARLEN_M1,
	input wire axiPkg::sizeT ARSIZE_M1,
	input wire axiPkg::burstT ARBURST_M1,
	input wire logic ARVALID_M1,
	output logic ARREADY_M1,
	output axiPkg::masterIdT RID_M1,
	output axiPkg::dataT RDATA_M1,
	output axiPkg::respT RRESP_M1,
	output logic RLAST_M1,
	output logic RVALID_M1,
	input wire logic RREADY_M1,

	// Slave 0
	output axiPkg::slaveIdT ARID_S0,
	output axiPkg::addrT ARADDR_S0,
	output axiPkg::lenT ARLEN_S0,
	output axiPkg::sizeT ARSIZE_S0,
	output axiPkg::burstT ARBURST_S0,
	output logic ARVALID_S0,
	input wire logic ARREADY_S0,
	input wire axiPkg::slaveIdT RID_S0,
	input wire axiPkg::dataT RDATA_S0,
	input wire axiPkg::respT RRESP_S0,
	input wire logic RLAST_S0,
	input wire logic RVALID_S0,
	output logic RREADY_S0,

	// Slave 1
	output axiPkg::slaveIdT ARID_S1,
	output axiPkg::addrT ARADDR_S1,
	output axiPkg::lenT ARLEN_S1,
	output axiPkg::sizeT ARSIZE_S1,
	output axiPkg::burstT ARBURST_S1,
	output logic ARVALID_S1,
	input wire logic ARREADY_S1,
	input wire axiPkg::slaveIdT RID_S1,
	input wire axiPkg::dataT RDATA_S1,
	input wire axiPkg::respT RRESP_S1,
	input wire logic RLAST_S1,
	input wire logic RVALID_S1,
	output logic RREADY_S1
);

	arChannelIf mAr0();
	arChannelIf mAr1();
	arChannelIf sAr0();
	arChannelIf sAr1();
	arChannelIf defAr();
	rChannelIf mR0();
	rChannelIf mR1();
	rChannelIf sR0();
	rChannelIf sR1();
	rChannelIf defR();

	logic burstDone;

	// Master ports, IDs zero extended inside
	assign mAr0.id = axiPkg::slaveIdT'(ARID_M0);
	assign mAr0.addr = ARADDR_M0;
	assign mAr0.len = ARLEN_M0;
	assign mAr0.size = ARSIZE_M0;
	assign mAr0.burst = ARBURST_M0;
	assign mAr0.valid = ARVALID_M0;
	assign ARREADY_M0 = mAr0.ready;
	assign RID_M0 = axiPkg::masterIdT'(mR0.id);
	assign RDATA_M0 = mR0.data;
	assign RRESP_M0 = mR0.resp;
	assign RLAST_M0 = mR0.last;
	assign RVALID_M0 = mR0.valid;
	assign mR0.ready = RREADY_M0;

	assign mAr1.id = axiPkg::slaveIdT'(ARID_M1);
	assign mAr1.addr = ARADDR_M1;
	assign mAr1.len = ARLEN_M1;
	assign mAr1.size = ARSIZE_M1;
	assign mAr1.burst = ARBURST_M1;
	assign mAr1.valid = ARVALID_M1;
	assign ARREADY_M1 = mAr1.ready;
	assign RID_M1 = axiPkg::masterIdT'(mR1.id);
	assign RDATA_M1 = mR1.data;
	assign RRESP_M1 = mR1.resp;
	assign RLAST_M1 = mR1.last;
	assign RVALID_M1 = mR1.valid;
	assign mR1.ready = RREADY_M1;

	// Slave ports
	assign ARID_S0 = sAr0.id;
	assign ARADDR_S0 = sAr0.addr;
	assign ARLEN_S0 = sAr0.len;
	assign ARSIZE_S0 = sAr0.size;
	assign ARBURST_S0 = sAr0.burst;
	assign ARVALID_S0 = sAr0.valid;
	assign sAr0.ready = ARREADY_S0;
	assign sR0.id = RID_S0;
	assign sR0.data = RDATA_S0;
	assign sR0.resp = RRESP_S0;
	assign sR0.last = RLAST_S0;
	assign sR0.valid = RVALID_S0;
	assign RREADY_S0 = sR0.ready;

	assign ARID_S1 = sAr1.id;
	assign ARADDR_S1 = sAr1.addr;
	assign ARLEN_S1 = sAr1.len;
	assign ARSIZE_S1 = sAr1.size;
	assign ARBURST_S1 = sAr1.burst;
	assign ARVALID_S1 = sAr1.valid;
	assign sAr1.ready = ARREADY_S1;
	assign sR1.id = RID_S1;
	assign sR1.data = RDATA_S1;
	assign sR1.resp = RRESP_S1;
	assign sR1.last = RLAST_S1;
	assign sR1.valid = RVALID_S1;
	assign RREADY_S1 = sR1.ready;

	arRouter arb (
		.ACLK(ACLK),
		.rst(rst),
		.mAr0(mAr0),
		.mAr1(mAr1),
		.sAr0(sAr0),
		.sAr1(sAr1),
		.defAr(defAr),
		.burstDone(burstDone)
	);

	defaultSlave defSlave (
		.ACLK(ACLK),
		.rst(rst),
		.ar(defAr),
		.r(defR)
	);

	readDataRouter rRouter (
		.sR0(sR0),
		.sR1(sR1),
		.defR(defR),
		.mR0(mR0),
		.mR1(mR1),
		.burstDone(burstDone)
	);

endmodule

`default_nettype wire

/* hdl/readDataRouter.sv */
`timescale 1ns/10ps
`default_nettype none
`include "axi_macros.svh"

module readDataRouter (
	rChannelIf.dst sR0,
	rChannelIf.dst sR1,
	rChannelIf.dst defR,
	rChannelIf.src mR0,
	rChannelIf.src mR1,
	output logic burstDone
);

	routePkg::targetT src;
	routePkg::masterSelT dstMaster;
	axiPkg::slaveIdT selId;
	axiPkg::masterIdT narrowId;
	axiPkg::dataT selData;
	axiPkg::respT selResp;
	logic selLast;
	logic selValid;
	logic selReady;

	// At most one source is busy, pick whichever is valid
	always_comb begin
		if (sR0.valid)
			src = routePkg::tgtS0;
		else if (sR1.valid)
			src = routePkg::tgtS1;
		else
			src = routePkg::tgtDefault;
	end

	always_comb begin
		case (src)
			routePkg::tgtS0: begin
				selId = sR0.id;
				selData = sR0.data;
				selResp = sR0.resp;
				selLast = sR0.last;
				selValid = sR0.valid;
			end
			routePkg::tgtS1: begin
				selId = sR1.id;
				selData = sR1.data;
				selResp = sR1.resp;
				selLast = sR1.last;
				selValid = sR1.valid;
			end
			default: begin
				selId = defR.id;
				selData = defR.data;
				selResp = defR.resp;
				selLast = defR.last;
				selValid = defR.valid;
			end
		endcase
	end

	// Upper nibble names the master, lower nibble is its own ID
	assign dstMaster = routePkg::masterSelT'(selId[`AXI_IDS_BITS-1:`AXI_ID_BITS]);
	assign narrowId = axiPkg::masterIdT'(selId);

	assign mR0.valid = selValid && (dstMaster == 1'b0);
	assign mR1.valid = selValid && (dstMaster == 1'b1);
	assign mR0.id = axiPkg::slaveIdT'(narrowId);
	assign mR1.id = axiPkg::slaveIdT'(narrowId);
	assign mR0.data = selData;
	assign mR1.data = selData;
	assign mR0.resp = selResp;
	assign mR1.resp = selResp;
	assign mR0.last = selLast;
	assign mR1.last = selLast;

	assign selReady = dstMaster ? mR1.ready : mR0.ready;
	assign sR0.ready = (src == routePkg::tgtS0) && selValid && selReady;
	assign sR1.ready = (src == routePkg::tgtS1) && selValid && selReady;
	assign defR.ready = (src == routePkg::tgtDefault) && selValid && selReady;

	// Last beat accepted by its master frees the arbiter
	assign burstDone = selValid && selReady && selLast;

endmodule

`default_nettype wire

/* hdl/defaultSlave.sv */
`timescale 1ns/10ps
`default_nettype none
`include "axi_macros.svh"

module defaultSlave (
	input wire logic ACLK,
	input wire logic rst,
	arChannelIf.dst ar,
	rChannelIf.src r
);

	routePkg::defStateT state;
	axiPkg::slaveIdT rspId;
	// Beats still to send after the current one
	axiPkg::lenT beatsLeft;

	// Takes a request whenever no burst is in flight
	assign ar.ready = (state == routePkg::defIdle);

	assign r.valid = (state == routePkg::defBeat);
	assign r.id = rspId;
	assign r.data = '0;
	assign r.resp = `RESP_DECERR;
	assign r.last = (beatsLeft == '0);

	always_ff @(posedge ACLK) begin
		if (rst) begin
			state <= routePkg::defIdle;
			beatsLeft <= '0;
		end else begin
			case (state)
				routePkg::defIdle: begin
					if (ar.valid) begin
						beatsLeft <= ar.len;
						state <= routePkg::defBeat;
					end
				end
				routePkg::defBeat: begin
					// r.valid is high here, so ready alone completes a beat
					if (r.ready) begin
						if (r.last)
							state <= routePkg::defIdle;
						else
							beatsLeft <= beatsLeft - axiPkg::lenT'(1);
					end
				end
			endcase
		end
	end

	always_ff @(posedge ACLK) begin
		if (state == routePkg::defIdle && ar.valid)
			rspId <= ar.id;
	end

endmodule

`default_nettype wire

/* hdl/arRouter.sv */
`timescale 1ns/10ps
`default_nettype none
`include "axi_macros.svh"

module arRouter (
	input wire logic ACLK,
	input wire logic rst,
	arChannelIf.dst mAr0,
	arChannelIf.dst mAr1,
	arChannelIf.src sAr0,
	arChannelIf.src sAr1,
	arChannelIf.src defAr,
	input wire logic burstDone
);

	routePkg::arbStateT state;
	// Master of the current or most recent burst
	routePkg::masterSelT grant;
	routePkg::masterSelT pick;
	routePkg::targetT target;
	logic arReady;
	logic arHs;
	logic anyReq;
	logic targetReady;

	axiPkg::masterIdT selId;
	axiPkg::addrT selAddr;
	axiPkg::slaveIdT reqId;
	axiPkg::addrT reqAddr;
	axiPkg::lenT reqLen;
	axiPkg::sizeT reqSize;
	axiPkg::burstT reqBurst;

	function automatic routePkg::targetT decode(input axiPkg::addrT a);
		if ((a - `S0_BASE) < `SLAVE_SPAN)
			return routePkg::tgtS0;
		else if ((a - `S1_BASE) < `SLAVE_SPAN)
			return routePkg::tgtS1;
		else
			return routePkg::tgtDefault;
	endfunction

	// Round robin, the master not granted last wins a tie
	assign anyReq = mAr0.valid | mAr1.valid;
	always_comb begin
		if (mAr0.valid && mAr1.valid)
			pick = ~grant;
		else if (mAr1.valid)
			pick = 1'b1;
		else
			pick = 1'b0;
	end

	// Request fields of the master holding the grant
	assign selId = grant ? mAr1.id[`AXI_ID_BITS-1:0] : mAr0.id[`AXI_ID_BITS-1:0];
	assign selAddr = grant ? mAr1.addr : mAr0.addr;
	assign arHs = arReady && (grant ? mAr1.valid : mAr0.valid);

	assign mAr0.ready = arReady && (grant == 1'b0);
	assign mAr1.ready = arReady && (grant == 1'b1);

	always_ff @(posedge ACLK) begin
		if (rst) begin
			state <= routePkg::arbIdle;
			arReady <= 1'b0;
			// M0 gets the first tie after reset
			grant <= 1'b1;
		end else begin
			case (state)
				routePkg::arbIdle: begin
					if (arReady) begin
						if (arHs) begin
							arReady <= 1'b0;
							state <= routePkg::arbIssue;
						end
					end else if (anyReq) begin
						arReady <= 1'b1;
						grant <= pick;
					end
				end
				routePkg::arbIssue: begin
					if (targetReady)
						state <= routePkg::arbWait;
				end
				routePkg::arbWait: begin
					// Hold off new grants until the last beat is delivered
					if (burstDone)
						state <= routePkg::arbIdle;
				end
				default: state <= routePkg::arbIdle;
			endcase
		end
	end

	// Latched request, ID widened with the master number
	always_ff @(posedge ACLK) begin
		if (state == routePkg::arbIdle && arHs) begin
			reqId <= {axiPkg::masterIdT'(grant), selId};
			reqAddr <= selAddr;
			reqLen <= grant ? mAr1.len : mAr0.len;
			reqSize <= grant ? mAr1.size : mAr0.size;
			reqBurst <= grant ? mAr1.burst : mAr0.burst;
			target <= decode(selAddr);
		end
	end

	always_comb begin
		case (target)
			routePkg::tgtS0: targetReady = sAr0.ready;
			routePkg::tgtS1: targetReady = sAr1.ready;
			default: targetReady = defAr.ready;
		endcase
	end

	assign sAr0.valid = (state == routePkg::arbIssue) && (target == routePkg::tgtS0);
	assign sAr1.valid = (state == routePkg::arbIssue) && (target == routePkg::tgtS1);
	assign defAr.valid = (state == routePkg::arbIssue) && (target == routePkg::tgtDefault);

	// Same payload on every target, only valid is steered
	assign sAr0.id = reqId;
	assign sAr0.addr = reqAddr;
	assign sAr0.len = reqLen;
	assign sAr0.size = reqSize;
	assign sAr0.burst = reqBurst;
	assign sAr1.id = reqId;
	assign sAr1.addr = reqAddr;
	assign sAr1.len = reqLen;
	assign sAr1.size = reqSize;
	assign sAr1.burst = reqBurst;
	assign defAr.id = reqId;
	assign defAr.addr = reqAddr;
	assign defAr.len = reqLen;
	assign defAr.size = reqSize;
	assign defAr.burst = reqBurst;

endmodule

`default_nettype wire

/* hdl/axiIfs.sv */
`timescale 1ns/10ps
`default_nettype none

// Read address channel
// Master side instances use only the lower nibble of id
interface arChannelIf;
	axiPkg::slaveIdT id;
	axiPkg::addrT addr;
	axiPkg::lenT len;
	axiPkg::sizeT size;
	axiPkg::burstT burst;
	logic valid;
	logic ready;

	modport src (
		output id, addr, len, size, burst, valid,
		input ready
	);

	modport dst (
		input id, addr, len, size, burst, valid,
		output ready
	);
endinterface

// Read data channel
interface rChannelIf;
	axiPkg::slaveIdT id;
	axiPkg::dataT data;
	axiPkg::respT resp;
	logic last;
	logic valid;
	logic ready;

	modport src (
		output id, data, resp, last, valid,
		input ready
	);

	modport dst (
		input id, data, resp, last, valid,
		output ready
	);
endinterface

`default_nettype wire

/* hdl/routePkg.sv */
`default_nettype none
`include "axi_macros.svh"

package routePkg;

	// Decoded destination of a read request
	typedef enum logic [1:0] {
		tgtS0,
		tgtS1,
		tgtDefault
	} targetT;

	// Read address arbiter
	typedef enum logic [1:0] {
		arbIdle,
		arbIssue,
		arbWait
	} arbStateT;

	// Default slave
	typedef enum logic {
		defIdle,
		defBeat
	} defStateT;

	typedef logic [$clog2(`AXI_MASTERS)-1:0] masterSelT;

endpackage

`default_nettype wire

/* hdl/axiPkg.sv */
`default_nettype none
`include "axi_macros.svh"

package axiPkg;

	// Master side ID
	typedef logic [`AXI_ID_BITS-1:0] masterIdT;

	// Slave side ID, master number in the upper nibble
	typedef logic [`AXI_IDS_BITS-1:0] slaveIdT;

	typedef logic [`AXI_ADDR_BITS-1:0] addrT;
	typedef logic [`AXI_DATA_BITS-1:0] dataT;

	// Beats minus one
	typedef logic [`AXI_LEN_BITS-1:0] lenT;

	typedef logic [`AXI_SIZE_BITS-1:0] sizeT;

	// Only INCR is carried through
	typedef logic [1:0] burstT;

	typedef logic [1:0] respT;

endpackage

`default_nettype wire

/* hdl/axi_macros.svh */
`ifndef AXI_MACROS_SVH
`define AXI_MACROS_SVH

// Bus field widths
`define AXI_ID_BITS   4
`define AXI_IDS_BITS  8
`define AXI_ADDR_BITS 32
`define AXI_DATA_BITS 32
`define AXI_LEN_BITS  4
`define AXI_SIZE_BITS 3

// Number of masters on the crossbar
`define AXI_MASTERS   2

// Address map, one 64 KiB window per slave
`define S0_BASE       32'h0000_0000
`define S1_BASE       32'h0001_0000
`define SLAVE_SPAN    32'h0001_0000

// Read response codes
`define RESP_OKAY     2'b00
`define RESP_DECERR   2'b11

`endif
